/* bench/calc_stimulus.mem */
// Columns: a keys (4 hex) | op (1 hex, 1 add 2 sub 4 mul) | b keys (4) | expected (4) | flags (3)
// Key 0 skips a slot, A is digit zero. Flags 1 stray equal, 2 stray operator, 4 keys in wait, 8 multi-hot op
01A51002A007D000 // 105 + 20
000320007FFFC000 // 3 - 7
0999409993A71000 // 999 * 999
9999199994E1E000 // 9999 + 9999
1AAA2000103E7000 // 1000 - 1
025A403AA24F8000 // 250 * 300
B1C213DEF000F000 // 12 + 3 with ignored codes
0042100080032001 // 42 + 8, equal before operator
000740006002A002 // 7 * 6, operator during second operand
05AA201230179004 // 500 - 123, keys while unit runs
000A400050000000 // 0 * 5
000A20001FFFF000 // 0 - 1
012310456024300F // 123 + 456, all stray inputs
4A96400160000000 // 4096 * 16
0009400090051000 // 9 * 9
123424321F3F1000 // 1234 - 4321
876514321331E000 // 8765 + 4321
025540257FFFF000 // 255 * 257

/* bench/calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int          NUM_DIRECTED   = 18;          // Records in the stimulus file
    localparam int          NUM_RANDOM     = 24;
    localparam int          TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 60;
    localparam logic [31:0] LFSR_SEED      = 32'hf93e_11e8;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic              clk;
    logic              nRST;
    logic [KEY_W-1:0]  keypad_input;
    logic [2:0]        operator_input;
    logic              equal_input;
    logic              complete;
    logic [DATA_W-1:0] display_output;

    logic [63:0]       stim_mem [NUM_DIRECTED];       // a keys, op, b keys, expected, flags
    logic [31:0]       lfsr_state;
    int                cycle_count;
    int                fail_count;

    calc_top u_calc_top (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 20 ns period
    end

    // Watchdog, every test fits well inside 60 cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: complete never arrived, run exceeded %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);       // One step per bit
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Decimal entry of four key slots, leftmost slot first
    function automatic logic [DATA_W-1:0] keys_to_value(input logic [15:0] keys);
        logic [DATA_W-1:0] acc;
        logic [3:0]        code;
        acc = '0;
        for (int i = 3; i >= 0; i--) begin
            code = keys[i*4 +: 4];
            if (code >= 4'd1 && code <= 4'd9) begin
                acc = acc * 16'd10 + {12'd0, code};
            end else if (code == KEY_ZERO) begin
                acc = acc * 16'd10;                   // Digit zero
            end
        end
        return acc;
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b,
                                                          input logic [2:0] op);
        logic [31:0] product;
        product = {16'd0, a} * {16'd0, b};
        case (op)
            OP_ADD:  return a + b;                    // Wraps at 16 bits
            OP_SUB:  return a - b;                    // Two's complement low half
            default: return product[15:0];
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        fail_count++;
        $display("CHECK FAILED %s expected %0d (0x%04h) actual %0d (0x%04h)",
                 name, expected, expected, actual, actual);
        $display("sim failed");
        $fatal(1, "Result mismatch");
    endtask

    task automatic report_error(input string what);
        fail_count++;
        $display("ERROR: %s", what);
        $display("sim failed");
        $fatal(1, "Check failed");
    endtask

    task automatic press_key(input logic [KEY_W-1:0] code);
        @(posedge clk);
        keypad_input <= code;
        @(posedge clk);
        keypad_input <= KEY_NONE;                     // Idle cycle between keys
    endtask

    task automatic pulse_operator(input logic [2:0] op);
        @(posedge clk);
        operator_input <= op;
        @(posedge clk);
        operator_input <= 3'b000;
    endtask

    task automatic pulse_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    task automatic run_calc(input string name, input logic [15:0] a_keys,
                            input logic [2:0] op, input logic [15:0] b_keys,
                            input logic [3:0] flags, input logic [DATA_W-1:0] expected);
        if (flags[0]) begin
            pulse_equal();                            // Equal before operator, ignored
        end
        for (int i = 3; i >= 0; i--) begin
            if (a_keys[i*4 +: 4] != KEY_NONE) begin
                press_key(a_keys[i*4 +: 4]);
            end
        end
        if (flags[3]) begin
            pulse_operator(3'b011);                   // Multi-hot strobe, ignored
        end
        pulse_operator(op);
        for (int i = 3; i >= 0; i--) begin
            if (b_keys[i*4 +: 4] != KEY_NONE) begin
                press_key(b_keys[i*4 +: 4]);
            end
        end
        if (flags[1]) begin
            pulse_operator({op[1:0], op[2]});         // Second operator, ignored
        end
        pulse_equal();
        if (flags[2]) begin
            for (int i = 0; i < 3; i++) begin
                press_key(4'(i * 3 + 2));             // Lands in WAIT_UNIT
            end
        end
        do begin
            @(negedge clk);
        end while (!complete);
        assert (display_output == expected) else report_mismatch(name, expected, display_output);
        @(negedge clk);
        assert (!complete) else report_error($sformatf("%s: complete longer than one cycle", name));
        assert (display_output == expected)
            else report_mismatch({name, " held"}, expected, display_output);
    endtask

    task automatic run_random(input int idx);
        logic [31:0] bits;
        logic [15:0] a_keys;
        logic [15:0] b_keys;
        logic [2:0]  op;
        logic [3:0]  flags;
        take_bits(16, bits);
        a_keys = bits[15:0];                          // Any code, skips and junk included
        take_bits(16, bits);
        b_keys = bits[15:0];
        take_bits(2, bits);
        case (bits[1:0])
            2'd0:    op = OP_ADD;
            2'd1:    op = OP_SUB;
            default: op = OP_MUL;
        endcase
        take_bits(4, bits);
        flags = bits[3:0];
        run_calc($sformatf("random %0d", idx), a_keys, op, b_keys, flags,
                 expected_result(keys_to_value(a_keys), keys_to_value(b_keys), op));
    endtask

    initial begin
        logic [63:0] rec;
        nRST           = 1'b1;
        keypad_input   = KEY_NONE;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        fail_count     = 0;
        lfsr_state     = LFSR_SEED;
        $readmemh("bench/calc_stimulus.mem", stim_mem);
        repeat (2) @(posedge clk);
        nRST <= 1'b0;
        repeat (4) begin                              // Quiet display before any key
            @(negedge clk);
            assert (display_output == 16'd0) else report_mismatch("after reset", 16'd0,
                                                                   display_output);
            assert (!complete) else report_error("complete pulsed with no calculation");
        end
        for (int t = 0; t < NUM_DIRECTED; t++) begin
            rec = stim_mem[t];
            assert ($onehot(rec[46:44]))
                else report_error($sformatf("stimulus record %0d has no valid operator", t));
            run_calc($sformatf("directed %0d", t), rec[63:48], rec[46:44], rec[43:28],
                     rec[3:0], rec[27:12]);
        end
        for (int t = 0; t < NUM_RANDOM; t++) begin
            run_random(t);                            // Entry restarts from zero each time
        end
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/calc_pkg.sv
logic/operand_entry.sv
logic/serial_addsub.sv
logic/shift_add_multiplier.sv
logic/calc_controller.sv
logic/calc_top.sv
bench/calc_tb.sv

/* logic/calc_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [2:0]                  operator_input,
    input  logic                        equal_input,
    input  calc_pkg::operand_pair_t     operands,
    output logic                        entry_a_en,
    output logic                        entry_b_en,
    output logic                        entry_clear,
    output calc_pkg::operand_pair_t     unit_operands,
    output logic                        addsub_start,
    output logic                        addsub_sub,
    output logic                        mul_start,
    input  logic [calc_pkg::DATA_W-1:0] addsub_result,
    input  logic                        addsub_finish,
    input  logic [calc_pkg::DATA_W-1:0] mul_result,
    input  logic                        mul_finish,
    output logic [calc_pkg::DATA_W-1:0] display_output,
    output logic                        complete
);
    import calc_pkg::*;

    calc_state_t       state;
    calc_state_t       next_state;
    op_t               op_reg;                     // Operator latched in first phase
    logic              op_valid;                   // Strobe is exactly one-hot
    logic              equal_ok;                   // Equal accepted this cycle
    logic              use_mul;                    // Route to multiplier
    logic              unit_done;                  // Finish from selected unit
    logic [DATA_W-1:0] unit_result;                // Result from selected unit

    // Zero and multi-hot strobes both fail this
    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    assign equal_ok = (state == GET_SECOND_NUM) && equal_input;

    assign use_mul     = (op_reg == OP_MUL);
    assign unit_done   = use_mul ? mul_finish : addsub_finish;
    assign unit_result = use_mul ? mul_result : addsub_result;

    // Entry enables follow the state directly
    assign entry_a_en  = (state == GET_FIRST_NUM);
    assign entry_b_en  = (state == GET_SECOND_NUM);
    assign entry_clear = (state == SHOW_RESULT);   // Accumulators zero on exit

    // Exactly one start in DISPATCH
    assign addsub_start = (state == DISPATCH) && !use_mul;
    assign mul_start    = (state == DISPATCH) && use_mul;
    assign addsub_sub   = (op_reg == OP_SUB);      // Held level, sampled on start

    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST_NUM: begin
                if (op_valid) begin
                    next_state = GET_SECOND_NUM;
                end
            end
            GET_SECOND_NUM: begin
                if (equal_input) begin             // Stray operators ignored here
                    next_state = DISPATCH;
                end
            end
            DISPATCH: begin
                next_state = WAIT_UNIT;
            end
            WAIT_UNIT: begin
                if (unit_done) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT: begin
                next_state = GET_FIRST_NUM;
            end
            default: begin
                next_state = GET_FIRST_NUM;        // Recover from unused codes
            end
        endcase
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state          <= GET_FIRST_NUM;
            op_reg         <= OP_NONE;
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            state    <= next_state;
            complete <= (state == SHOW_RESULT);    // High while new value first shows
            if ((state == GET_FIRST_NUM) && op_valid) begin
                op_reg <= op_t'(operator_input);
            end
            if (state == SHOW_RESULT) begin
                display_output <= unit_result;     // Held until next result
            end
        end
    end

    // Snapshot operands when equal is taken
    always_ff @(posedge clk) begin
        if (equal_ok) begin
            unit_operands <= operands;
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (nRST)
        !(addsub_start && mul_start));

    a_op_onehot: assert property (@(posedge clk) disable iff (nRST)
        (state != GET_FIRST_NUM) |-> $onehot(op_reg));

endmodule

`default_nettype wire

/* logic/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    localparam int DATA_W      = 16;               // Operand and result width
    localparam int KEY_W       = 4;                // Keypad code width
    localparam int UNIT_CYCLES = DATA_W;           // One iteration per result bit
    localparam int CNT_W       = $clog2(UNIT_CYCLES);

    localparam logic [KEY_W-1:0] KEY_NONE = 4'd0;  // Idle keypad
    localparam logic [KEY_W-1:0] KEY_ZERO = 4'd10; // Digit 0 lives above 9

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(UNIT_CYCLES - 1); // Final iteration index

    // Encoded to match the one-hot operator strobe
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } op_t;

    typedef enum logic [2:0] {
        GET_FIRST_NUM  = 3'd0,                     // Collecting operand a
        GET_SECOND_NUM = 3'd1,                     // Collecting operand b
        DISPATCH       = 3'd2,                     // Start pulse to chosen unit
        WAIT_UNIT      = 3'd3,                     // Unit iterating
        SHOW_RESULT    = 3'd4                      // Load display, clear entry
    } calc_state_t;

    typedef struct packed {
        logic [DATA_W-1:0] a;                      // Left operand
        logic [DATA_W-1:0] b;                      // Right operand
    } operand_pair_t;

endpackage

`default_nettype wire

/* logic/calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::KEY_W-1:0]  keypad_input,
    input  logic [2:0]                  operator_input,
    input  logic                        equal_input,
    output logic                        complete,
    output logic [calc_pkg::DATA_W-1:0] display_output
);
    import calc_pkg::*;

    logic              entry_a_en;
    logic              entry_b_en;
    logic              entry_clear;
    logic [DATA_W-1:0] value_a;                    // Live accumulator a
    logic [DATA_W-1:0] value_b;                    // Live accumulator b
    operand_pair_t     operands;                   // Both accumulators to controller
    operand_pair_t     unit_operands;              // Controller snapshot for units
    logic              addsub_start;
    logic              addsub_sub;
    logic              addsub_finish;
    logic [DATA_W-1:0] addsub_result;
    logic              mul_start;
    logic              mul_finish;
    logic [DATA_W-1:0] mul_result;

    assign operands = '{a: value_a, b: value_b};

    // Keypad fans out, enable picks the operand
    operand_entry u_entry_a (
        .clk   (clk),
        .nRST  (nRST),
        .en    (entry_a_en),
        .clear (entry_clear),
        .key   (keypad_input),
        .value (value_a)
    );

    operand_entry u_entry_b (
        .clk   (clk),
        .nRST  (nRST),
        .en    (entry_b_en),
        .clear (entry_clear),
        .key   (keypad_input),
        .value (value_b)
    );

    serial_addsub u_addsub (
        .clk      (clk),
        .nRST     (nRST),
        .start    (addsub_start),
        .sub      (addsub_sub),
        .operands (unit_operands),
        .result   (addsub_result),
        .finish   (addsub_finish)
    );

    shift_add_multiplier u_mul (
        .clk      (clk),
        .nRST     (nRST),
        .start    (mul_start),
        .operands (unit_operands),
        .result   (mul_result),
        .finish   (mul_finish)
    );

    calc_controller u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .operands       (operands),
        .entry_a_en     (entry_a_en),
        .entry_b_en     (entry_b_en),
        .entry_clear    (entry_clear),
        .unit_operands  (unit_operands),
        .addsub_start   (addsub_start),
        .addsub_sub     (addsub_sub),
        .mul_start      (mul_start),
        .addsub_result  (addsub_result),
        .addsub_finish  (addsub_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

`default_nettype wire

/* logic/operand_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_entry (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        en,
    input  logic                        clear,
    input  logic [calc_pkg::KEY_W-1:0]  key,
    output logic [calc_pkg::DATA_W-1:0] value
);
    import calc_pkg::*;

    logic              is_digit;                   // Key carries a decimal digit
    logic [DATA_W-1:0] digit;                      // Zero-extended digit value
    logic [DATA_W-1:0] times_ten;                  // value * 10, wraps

    // Codes 1..10 are digits, 11..15 and idle are not
    assign is_digit = (key != KEY_NONE) && (key <= KEY_ZERO);

    // Code 10 maps back to digit 0
    assign digit = (key == KEY_ZERO) ? '0 : {{(DATA_W-KEY_W){1'b0}}, key};

    // x*8 + x*2, no multiplier needed
    assign times_ten = (value << 3) + (value << 1);

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            value <= '0;
        end else if (clear) begin                  // Clear wins over entry
            value <= '0;
        end else if (en && is_digit) begin
            value <= times_ten + digit;            // Shift in next decimal digit
        end
    end

endmodule

`default_nettype wire

/* logic/serial_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_addsub (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  logic                        sub,
    input  calc_pkg::operand_pair_t     operands,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);
    import calc_pkg::*;

    logic              busy;                       // Iteration in progress
    logic [CNT_W-1:0]  bit_cnt;                    // Current bit position
    logic [DATA_W-1:0] a_reg;                      // Shifts right, LSB consumed
    logic [DATA_W-1:0] b_reg;                      // Inverted for subtract
    logic              carry;                      // Ripple carry between cycles
    logic [DATA_W-1:0] sum_reg;                    // Sum bits enter at MSB
    logic              sum_bit;
    logic              carry_next;

    // One full adder, reused every cycle
    assign sum_bit    = a_reg[0] ^ b_reg[0] ^ carry;
    assign carry_next = (a_reg[0] & b_reg[0]) | (carry & (a_reg[0] ^ b_reg[0]));
    assign result     = sum_reg;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;                        // Single-cycle pulse
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_CNT) begin     // Last sum bit this cycle
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_reg <= operands.a;
            b_reg <= sub ? ~operands.b : operands.b; // a + ~b + 1 for subtract
            carry <= sub;
        end else if (busy) begin
            a_reg   <= a_reg >> 1;
            b_reg   <= b_reg >> 1;
            carry   <= carry_next;
            sum_reg <= {sum_bit, sum_reg[DATA_W-1:1]}; // LSB first, ends aligned
        end
    end

    a_finish_single: assert property (@(posedge clk) disable iff (nRST)
        finish |=> !finish);

    a_no_start_busy: assert property (@(posedge clk) disable iff (nRST)
        start |-> !busy);

endmodule

`default_nettype wire

/* logic/shift_add_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  calc_pkg::operand_pair_t     operands,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);
    import calc_pkg::*;

    logic              busy;                       // Iteration in progress
    logic [CNT_W-1:0]  bit_cnt;                    // Multiplier bit index
    logic [DATA_W-1:0] mcand;                      // Multiplicand, shifts left
    logic [DATA_W-1:0] mplier;                     // Multiplier, shifts right
    logic [DATA_W-1:0] acc;                        // Low half of product
    logic [DATA_W-1:0] acc_next;

    // Add partial product when current multiplier bit is set
    assign acc_next = mplier[0] ? (acc + mcand) : acc;
    assign result   = acc;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_CNT) begin     // Last partial product
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // High product bits fall off the top of mcand, so result wraps
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= operands.a;
            mplier <= operands.b;
            acc    <= '0;                          // Fresh product each start
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Only one product in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (nRST)
        start |-> !busy);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the calculator testbench with Verilator, run it, judge by sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module calc_tb -f filelist.f -o calc_sim \
    && { ./obj_dir/calc_sim > sim.log 2>&1 || true; } \
    && grep -qx "sim passed" sim.log \
    && { echo "PASS: see sim.log"; exit 0; } \
    || { echo "FAIL: build or simulation failed, see sim.log"; exit 1; }
